// File: source/pcie_lite_params.svh
/*
 * widths, register count, queue depths and initial credits of the lite endpoint.
 */
`ifndef PCIE_LITE_PARAMS_SVH
`define PCIE_LITE_PARAMS_SVH

`define DATA_W            32    // register and payload word width.
`define TAG_W             8     // requester tag width.
`define REG_COUNT         16    // number of BAR0 registers.
`define REG_ADDR_W        4     // word index taken from the dword address.
`define BAR0_NUM          3'd0  // bar_range value of the register BAR.

`define REQ_FIFO_DEPTH    4     // queued read requests.
`define CPL_FIFO_DEPTH    4     // queued completions.

`define CPL_CREDITS_INIT  4     // completion header credits after reset.
`define CREDIT_W          4     // credit counter width.

`endif

// File: source/pcie_lite_pkg.sv
/*
 * request, read queue and completion types plus the kind and status encodings.
 */
`include "pcie_lite_params.svh"

package pcie_lite_pkg;

    ////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic {
        REQ_READ  = 1'b0,  // memory read, needs a completion.
        REQ_WRITE = 1'b1   // memory write, posted.
    } req_kind_e;

    typedef enum logic {
        CPL_SC = 1'b0,  // successful completion.
        CPL_UR = 1'b1   // unsupported request.
    } cpl_status_e;

    ////////////////////////////////////////////////////////////
    // receive side
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        req_kind_e         kind;  // read or write.
        logic [`TAG_W-1:0] tag;   // echoed back in the completion.
        logic [2:0]        bar;   // bar_range style BAR number.
        logic [`DATA_W-1:0] addr; // dword address inside the BAR.
    } req_hdr_t;

    typedef struct packed {
        req_hdr_t           hdr;  // request header.
        logic [`DATA_W-1:0] data; // write data, ignored for reads.
    } req_beat_t;

    // one read waiting for the register file.
    typedef struct packed {
        logic [`TAG_W-1:0]      tag;
        logic [2:0]             bar;
        logic [`REG_ADDR_W-1:0] index; // register word index.
    } rd_req_t;

    ////////////////////////////////////////////////////////////
    // transmit side
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [`TAG_W-1:0]  tag;    // tag of the originating read.
        cpl_status_e        status;
        logic [`DATA_W-1:0] data;   // zero on UR.
    } cpl_beat_t;

endpackage

// File: source/stream_fifo.sv
/*
 * synchronous circular-buffer FIFO, payload type and depth set per instance.
 */
`resetall
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
    parameter type payload_t = logic [7:0],  // entry type.
    parameter int  DEPTH     = 4              // number of entries.
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     push,       // write strobe, ignored while full.
    input  payload_t push_data,
    output logic     full,
    input  logic     pop,        // read strobe, ignored while empty.
    output payload_t pop_data,   // head entry, valid while not empty.
    output logic     empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];  // entry storage.
    logic [PTR_W-1:0] wr_ptr;       // next slot to fill.
    logic [PTR_W-1:0] rd_ptr;       // current head.
    logic [CNT_W-1:0] count;        // occupancy.
    logic             do_push;
    logic             do_pop;

    // pointer step with wrap, depth need not be a power of two.
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
    endfunction

    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign pop_data = mem[rd_ptr];  // head comes straight from the storage registers.

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;  // payload only, no reset.
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= ptr_next(wr_ptr);
            if (do_pop)  rd_ptr <= ptr_next(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + CNT_W'(1);  // fill.
                2'b01:   count <= count - CNT_W'(1);  // drain.
                default: count <= count;               // idle or pass-through.
            endcase
        end
    end

endmodule

`resetall

// File: source/rx_req_demux.sv
/*
 * receive stream decode: BAR0 writes to the register port, reads to the read queue.
 */
`resetall
`timescale 1ns/1ps
`default_nettype none

`include "pcie_lite_params.svh"

module rx_req_demux (
    // receive stream
    input  logic                       rx_st_valid,
    input  pcie_lite_pkg::req_beat_t   rx_st_beat,
    output logic                       rx_st_ready,

    // register write port
    output logic                       wr_en,     // one cycle per BAR0 write.
    output logic [`REG_ADDR_W-1:0]     wr_index,
    output logic [`DATA_W-1:0]         wr_data,

    // read request queue
    output logic                       rdq_push,
    output pcie_lite_pkg::rd_req_t     rdq_data,
    input  logic                       rdq_full
);

    import pcie_lite_pkg::*;

    logic accept;     // beat transfers this cycle.
    logic is_write;   // decoded kind.
    logic hit_bar0;   // request targets the register BAR.

    ////////////////////////////////////////////////////////////
    // handshake
    ////////////////////////////////////////////////////////////

    // ready looks at queue space only, never at valid.
    // writes stall too while the read queue is full.
    assign rx_st_ready = !rdq_full;
    assign accept      = rx_st_valid && rx_st_ready;

    ////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////

    assign is_write = (rx_st_beat.hdr.kind == REQ_WRITE);
    assign hit_bar0 = (rx_st_beat.hdr.bar == `BAR0_NUM);

    // writes go straight to the register file.
    // note they can overtake reads still sitting in the queue.
    assign wr_en    = accept && is_write && hit_bar0;  // other BARs dropped here.
    assign wr_index = rx_st_beat.hdr.addr[`REG_ADDR_W-1:0];  // dword address low bits.
    assign wr_data  = rx_st_beat.data;

    // every read is queued with its BAR, bar_target decides SC or UR.
    assign rdq_push       = accept && !is_write;
    assign rdq_data.tag   = rx_st_beat.hdr.tag;
    assign rdq_data.bar   = rx_st_beat.hdr.bar;
    assign rdq_data.index = rx_st_beat.hdr.addr[`REG_ADDR_W-1:0];

endmodule

`resetall

// File: source/bar_target.sv
/*
 * BAR0 register file, write port and read service that builds completions.
 */
`resetall
`timescale 1ns/1ps
`default_nettype none

`include "pcie_lite_params.svh"

module bar_target (
    input  logic                       clk,
    input  logic                       arst_n,

    // register write port
    input  logic                       wr_en,
    input  logic [`REG_ADDR_W-1:0]     wr_index,
    input  logic [`DATA_W-1:0]         wr_data,

    // read request queue
    input  logic                       rdq_empty,
    input  pcie_lite_pkg::rd_req_t     rdq_data,
    output logic                       rdq_pop,

    // completion queue
    input  logic                       cplq_full,
    output logic                       cplq_push,
    output pcie_lite_pkg::cpl_beat_t   cplq_data,

    output logic [3:0]                 reg0_low   // feeds the LEDs.
);

    import pcie_lite_pkg::*;

    logic [`DATA_W-1:0] regs [`REG_COUNT];  // BAR0 register array.
    logic               rd_hit;             // queued read targets BAR0.

    ////////////////////////////////////////////////////////////
    // register file
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;  // registers read as zero after reset.
            end
        end else if (wr_en) begin
            regs[wr_index] <= wr_data;
        end
    end

    assign reg0_low = regs[0][3:0];

    ////////////////////////////////////////////////////////////
    // read service
    ////////////////////////////////////////////////////////////

    // one read per cycle, moved only when the completion queue has room.
    // the completion is captured by the completion queue at the same edge.
    assign rdq_pop   = !rdq_empty && !cplq_full;
    assign cplq_push = rdq_pop;

    assign rd_hit = (rdq_data.bar == `BAR0_NUM);

    always_comb begin
        cplq_data.tag    = rdq_data.tag;  // echo the requester tag.
        cplq_data.status = rd_hit ? CPL_SC : CPL_UR;
        cplq_data.data   = rd_hit ? regs[rdq_data.index] : '0;  // UR carries no data.
    end

endmodule

`resetall

// File: source/tx_credit_gate.sv
/*
 * completion header credit counter and registered transmit stream output.
 */
`resetall
`timescale 1ns/1ps
`default_nettype none

`include "pcie_lite_params.svh"

module tx_credit_gate (
    input  logic                       clk,
    input  logic                       arst_n,

    // completion queue
    input  logic                       cplq_empty,
    input  pcie_lite_pkg::cpl_beat_t   cplq_data,
    output logic                       cplq_pop,

    // credit return from the link partner
    input  logic                       tx_credit_return,  // one pulse, one credit.

    // transmit stream, no ready
    output logic                       tx_st_valid,
    output pcie_lite_pkg::cpl_beat_t   tx_st_cpl
);

    import pcie_lite_pkg::*;

    logic [`CREDIT_W-1:0] credit_cnt;  // completion header credits left.
    logic                 has_credit;
    logic                 send;        // completion leaves this cycle.

    ////////////////////////////////////////////////////////////
    // send decision
    ////////////////////////////////////////////////////////////

    assign has_credit = (credit_cnt != '0);
    assign send       = !cplq_empty && has_credit;  // receiver space is promised.
    assign cplq_pop   = send;

    ////////////////////////////////////////////////////////////
    // credit counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credit_cnt <= `CREDIT_W'(`CPL_CREDITS_INIT);
        end else begin
            case ({send, tx_credit_return})
                2'b10:   credit_cnt <= credit_cnt - `CREDIT_W'(1);  // consume.
                2'b01:   credit_cnt <= credit_cnt + `CREDIT_W'(1);  // returned.
                default: credit_cnt <= credit_cnt;  // idle, or send and return cancel.
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tx_st_valid <= 1'b0;
        end else begin
            tx_st_valid <= send;  // exactly one cycle per completion.
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            tx_st_cpl <= cplq_data;  // holds last completion between sends.
        end
    end

endmodule

`resetall

// File: source/example_core.sv
/*
 * endpoint datapath: receive demux, read queue, BAR0 target, completion queue, credit gate.
 */
`resetall
`timescale 1ns/1ps
`default_nettype none

`include "pcie_lite_params.svh"

module example_core (
    input  logic                       clk,
    input  logic                       arst_n,

    // receive stream
    input  logic                       rx_st_valid,
    input  pcie_lite_pkg::req_beat_t   rx_st_beat,
    output logic                       rx_st_ready,

    // transmit stream and flow control
    output logic                       tx_st_valid,
    output pcie_lite_pkg::cpl_beat_t   tx_st_cpl,
    input  logic                       tx_credit_return,

    output logic [3:0]                 reg0_low
);

    import pcie_lite_pkg::*;

    // register write port.
    logic                   wr_en;
    logic [`REG_ADDR_W-1:0] wr_index;
    logic [`DATA_W-1:0]     wr_data;

    // read request queue handshake.
    logic    rdq_push, rdq_pop, rdq_full, rdq_empty;
    rd_req_t rdq_in, rdq_out;

    // completion queue handshake.
    logic      cplq_push, cplq_pop, cplq_full, cplq_empty;
    cpl_beat_t cplq_in, cplq_out;

    rx_req_demux i_demux (
        .rx_st_valid (rx_st_valid), .rx_st_beat (rx_st_beat), .rx_st_ready (rx_st_ready),
        .wr_en       (wr_en),       .wr_index   (wr_index),   .wr_data     (wr_data),
        .rdq_push    (rdq_push),    .rdq_data   (rdq_in),     .rdq_full    (rdq_full)
    );

    stream_fifo #(.payload_t(rd_req_t), .DEPTH(`REQ_FIFO_DEPTH)) i_rd_fifo (
        .clk  (clk),     .arst_n    (arst_n),
        .push (rdq_push), .push_data (rdq_in),  .full  (rdq_full),
        .pop  (rdq_pop),  .pop_data  (rdq_out), .empty (rdq_empty)
    );

    bar_target i_bar (
        .clk       (clk),       .arst_n    (arst_n),
        .wr_en     (wr_en),     .wr_index  (wr_index), .wr_data   (wr_data),
        .rdq_empty (rdq_empty), .rdq_data  (rdq_out),  .rdq_pop   (rdq_pop),
        .cplq_full (cplq_full), .cplq_push (cplq_push), .cplq_data (cplq_in),
        .reg0_low  (reg0_low)
    );

    stream_fifo #(.payload_t(cpl_beat_t), .DEPTH(`CPL_FIFO_DEPTH)) i_cpl_fifo (
        .clk  (clk),       .arst_n    (arst_n),
        .push (cplq_push), .push_data (cplq_in),  .full  (cplq_full),
        .pop  (cplq_pop),  .pop_data  (cplq_out), .empty (cplq_empty)
    );

    tx_credit_gate i_gate (
        .clk              (clk),              .arst_n      (arst_n),
        .cplq_empty       (cplq_empty),       .cplq_data   (cplq_out), .cplq_pop (cplq_pop),
        .tx_credit_return (tx_credit_return),
        .tx_st_valid      (tx_st_valid),      .tx_st_cpl   (tx_st_cpl)
    );

endmodule

`resetall

// File: source/fpga_core.sv
/*
 * top level of the lite endpoint, streams, credit return and user LEDs.
 */
`resetall
`timescale 1ns/1ps
`default_nettype none

module fpga_core (
    input  logic                       clk,
    input  logic                       arst_n,

    // GPIO
    output logic [3:0]                 user_led,  // low bits of BAR0 register 0.

    // receive stream
    input  logic                       rx_st_valid,
    input  pcie_lite_pkg::req_beat_t   rx_st_beat,
    output logic                       rx_st_ready,

    // transmit stream
    output logic                       tx_st_valid,
    output pcie_lite_pkg::cpl_beat_t   tx_st_cpl,
    input  logic                       tx_credit_return   // completion header credit.
);

    logic [3:0] reg0_low;  // straight from the register file.

    example_core i_core (
        .clk              (clk),
        .arst_n           (arst_n),
        .rx_st_valid      (rx_st_valid),
        .rx_st_beat       (rx_st_beat),
        .rx_st_ready      (rx_st_ready),
        .tx_st_valid      (tx_st_valid),
        .tx_st_cpl        (tx_st_cpl),
        .tx_credit_return (tx_credit_return),
        .reg0_low         (reg0_low)
    );

    // LED register, one cycle behind register 0.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            user_led <= 4'h0;
        end else begin
            user_led <= reg0_low;
        end
    end

endmodule

`resetall

// File: testbench/tb_fpga_core.sv
/*
 * lite endpoint testbench with clock, reset, request stimulus and credit return
 * plus a reference register model and the completion compare.
 */
`timescale 1ns/1ps

`include "pcie_lite_params.svh"

module tb_fpga_core;

    import pcie_lite_pkg::*;

    localparam int WAIT_LIMIT = 400;  // cycles any single wait may take.
    localparam int EXP_DEPTH  = 64;   // expected completion ring.
    localparam int FULL_LOAD  = `CPL_CREDITS_INIT + `CPL_FIFO_DEPTH + `REQ_FIFO_DEPTH;

    logic        clk;
    logic        arst_n;
    logic [3:0]  user_led;
    logic        rx_st_valid;
    req_beat_t   rx_st_beat;
    logic        rx_st_ready;
    logic        tx_st_valid;
    cpl_beat_t   tx_st_cpl;
    logic        tx_credit_return = 1'b0;  // owned by the compare process.

    int          seed = 32'ha253_e74b;
    logic [`DATA_W-1:0] ref_regs [`REG_COUNT];  // model of the BAR0 registers.
    cpl_beat_t   exp_mem [EXP_DEPTH];           // completions still to come in order.
    int          exp_wr = 0;                    // written by stimulus only.
    int          exp_rd = 0;                    // advanced by compare only.
    int          cpl_seen = 0;                  // completions observed on tx.
    int          credits_returned = 0;          // return pulses driven so far.
    logic        credit_hold = 1'b0;            // returns stop at grant_limit when set.
    int          grant_limit = 0;
    int          stim_errors = 0;
    int          cpl_errors = 0;
    int          stim_checks = 0;
    int          cpl_checks = 0;
    int          tests_run = 0;
    int          err_base = 0;
    string       test_name = "reset";

    fpga_core i_dut (
        .clk              (clk),
        .arst_n           (arst_n),
        .user_led         (user_led),
        .rx_st_valid      (rx_st_valid),
        .rx_st_beat       (rx_st_beat),
        .rx_st_ready      (rx_st_ready),
        .tx_st_valid      (tx_st_valid),
        .tx_st_cpl        (tx_st_cpl),
        .tx_credit_return (tx_credit_return)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 100 MHz.
    end

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    // completion a read should produce. BAR0 gives data and any other BAR gives UR.
    function automatic cpl_beat_t expect_cpl(input logic [`TAG_W-1:0] tag,
                                             input logic [2:0] bar,
                                             input logic [`REG_ADDR_W-1:0] index);
        cpl_beat_t c;
        c.tag = tag;
        if (bar == `BAR0_NUM) begin
            c.status = CPL_SC;
            c.data   = ref_regs[index];
        end else begin
            c.status = CPL_UR;
            c.data   = '0;
        end
        return c;
    endfunction

    ////////////////////////////////////////////////////////////
    // compare and credit return on the falling edge
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        cpl_beat_t exp;
        int        limit;
        if (arst_n) begin
            if (tx_st_valid) begin
                cpl_seen++;
                cpl_checks++;
                if (exp_rd == exp_wr) begin
                    $display("%s: completion tag %02h arrived with no read outstanding",
                             test_name, tx_st_cpl.tag);
                    cpl_errors++;
                end else begin
                    exp = exp_mem[exp_rd % EXP_DEPTH];
                    exp_rd++;
                    if (tx_st_cpl !== exp) begin
                        // values shown as tag/status/data.
                        $display("Mismatch %s: expected %02h/%0d/%08h, actual %02h/%0d/%08h",
                                 test_name, exp.tag, exp.status, exp.data,
                                 tx_st_cpl.tag, tx_st_cpl.status, tx_st_cpl.data);
                        cpl_errors++;
                    end
                end
                if (cpl_seen > `CPL_CREDITS_INIT + credits_returned) begin
                    $display("%s: more completions sent than credits granted", test_name);
                    cpl_errors++;
                end
            end
            limit = credit_hold ? grant_limit : cpl_seen;  // auto mode returns what was used.
            if (credits_returned < limit) begin
                tx_credit_return = 1'b1;
                credits_returned++;
            end else begin
                tx_credit_return = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus tasks start and end just after a falling edge
    ////////////////////////////////////////////////////////////

    task automatic send_beat(input req_kind_e kind, input logic [2:0] bar,
                             input logic [`REG_ADDR_W-1:0] index,
                             input logic [`DATA_W-1:0] data);
        int                waited;
        logic [`TAG_W-1:0] tag;
        waited = 0;
        tag    = `TAG_W'($random(seed));
        rx_st_beat.hdr.kind = kind;
        rx_st_beat.hdr.tag  = tag;
        rx_st_beat.hdr.bar  = bar;
        rx_st_beat.hdr.addr = `DATA_W'(index);
        rx_st_beat.data     = (kind == REQ_WRITE) ? data : '0;
        rx_st_valid         = 1'b1;
        // ready only moves after a rising edge so its value here holds for the next one.
        while (!rx_st_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!rx_st_ready) begin
            $display("%s: rx_st_ready stayed low, beat never accepted", test_name);
            stim_errors++;
        end else if (kind == REQ_WRITE) begin
            if (bar == `BAR0_NUM) ref_regs[index] = data;  // other BARs leave the model alone.
        end else begin
            exp_mem[exp_wr % EXP_DEPTH] = expect_cpl(tag, bar, index);
            exp_wr++;
        end
        @(negedge clk);  // transfer happens on the rising edge in between.
        rx_st_valid = 1'b0;
    endtask

    // wait until every expected completion arrived and all credits are back in auto mode.
    task automatic drain();
        int waited;
        waited = 0;
        while ((exp_wr != exp_rd || (!credit_hold && credits_returned != cpl_seen))
               && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_wr != exp_rd) begin
            $display("%s: timed out with %0d completions missing", test_name, exp_wr - exp_rd);
            stim_errors++;
        end
        repeat (4) @(negedge clk);  // room for a stray extra completion to show up.
    endtask

    task automatic check_count(input int expected, input int actual);
        stim_checks++;
        if (expected != actual) begin
            $display("Mismatch %s: expected %0d completions, actual %0d",
                     test_name, expected, actual);
            stim_errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_base  = stim_errors + cpl_errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (stim_errors + cpl_errors == err_base) begin
            $display("test %s: pass", test_name);
        end else begin
            $display("test %s: fail, %0d errors", test_name, stim_errors + cpl_errors - err_base);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int                 base;
        logic [`DATA_W-1:0] led_data;
        arst_n      = 1'b0;
        rx_st_valid = 1'b0;
        rx_st_beat  = '0;
        for (int i = 0; i < `REG_COUNT; i++) ref_regs[i] = '0;  // cleared by reset.
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        start_test("reset_state");
        stim_checks++;
        if (rx_st_ready !== 1'b1 || tx_st_valid !== 1'b0) begin
            $display("%s: rx_st_ready low or tx_st_valid high after reset", test_name);
            stim_errors++;
        end
        end_test();

        start_test("bar0_write_read");
        base = cpl_seen;
        for (int i = 0; i < `REG_COUNT; i++) begin
            send_beat(REQ_WRITE, 3'd0, `REG_ADDR_W'(i), $random(seed));
        end
        for (int i = 0; i < `REG_COUNT; i++) begin
            send_beat(REQ_READ, 3'd0, `REG_ADDR_W'(i), '0);
        end
        drain();
        check_count(`REG_COUNT, cpl_seen - base);
        end_test();

        start_test("other_bars");
        base = cpl_seen;
        for (int i = 0; i < 4; i++) begin
            send_beat(REQ_WRITE, 3'd2, `REG_ADDR_W'(4 * i), $random(seed));
        end
        for (int i = 0; i < 4; i++) begin
            send_beat(REQ_WRITE, 3'd4, `REG_ADDR_W'(4 * i + 2), $random(seed));
        end
        for (int i = 0; i < 8; i++) begin
            send_beat(REQ_READ, 3'd0, `REG_ADDR_W'(2 * i), '0);  // must be unchanged.
        end
        for (int i = 0; i < 3; i++) begin
            send_beat(REQ_READ, 3'd2, `REG_ADDR_W'(i), '0);
        end
        for (int i = 0; i < 3; i++) begin
            send_beat(REQ_READ, 3'd4, `REG_ADDR_W'(i + 5), '0);
        end
        drain();
        check_count(14, cpl_seen - base);
        end_test();

        start_test("credit_limit");
        base        = cpl_seen;
        grant_limit = credits_returned;  // freeze returns.
        credit_hold = 1'b1;
        for (int i = 0; i < 8; i++) begin
            send_beat(REQ_READ, 3'd0, `REG_ADDR_W'($random(seed)), '0);
        end
        repeat (60) @(negedge clk);  // long wait with nothing beyond the initial grant.
        check_count(`CPL_CREDITS_INIT, cpl_seen - base);
        grant_limit = credits_returned + 8 - `CPL_CREDITS_INIT;
        drain();
        check_count(8, cpl_seen - base);
        credit_hold = 1'b0;
        drain();
        end_test();

        start_test("order_and_tags");
        base = cpl_seen;
        for (int i = 0; i < 12; i++) begin
            send_beat(REQ_READ, (i % 3 == 0) ? 3'd4 : 3'd0, `REG_ADDR_W'($random(seed)), '0);
        end
        drain();
        check_count(12, cpl_seen - base);
        end_test();

        start_test("backpressure");
        base        = cpl_seen;
        grant_limit = credits_returned;
        credit_hold = 1'b1;
        for (int i = 0; i < FULL_LOAD; i++) begin
            send_beat(REQ_READ, 3'd0, `REG_ADDR_W'($random(seed)), '0);
        end
        repeat (20) @(negedge clk);
        stim_checks++;
        if (rx_st_ready !== 1'b0) begin
            $display("%s: rx_st_ready still high with both queues full", test_name);
            stim_errors++;
        end
        check_count(`CPL_CREDITS_INIT, cpl_seen - base);
        credit_hold = 1'b0;  // released credits let the stream resume.
        for (int i = 0; i < 4; i++) begin
            send_beat(REQ_READ, 3'd0, `REG_ADDR_W'($random(seed)), '0);
        end
        drain();
        check_count(FULL_LOAD + 4, cpl_seen - base);
        end_test();

        start_test("user_led");
        led_data      = $random(seed);
        led_data[3:0] = ~ref_regs[0][3:0];  // low bits always change.
        send_beat(REQ_WRITE, 3'd0, '0, led_data);
        repeat (3) @(negedge clk);  // register edge plus LED register edge.
        stim_checks++;
        if (user_led !== ref_regs[0][3:0]) begin
            $display("Mismatch %s: expected %h, actual %h",
                     test_name, ref_regs[0][3:0], user_led);
            stim_errors++;
        end
        end_test();

        $display("tests %0d, checks %0d, errors %0d", tests_run,
                 stim_checks + cpl_checks, stim_errors + cpl_errors);
        if (stim_errors + cpl_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+source
source/pcie_lite_pkg.sv
source/stream_fifo.sv
source/rx_req_demux.sv
source/bar_target.sv
source/tx_credit_gate.sv
source/example_core.sv
source/fpga_core.sv
testbench/tb_fpga_core.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and pass only if the pass message shows up.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f build.f --top-module tb_fpga_core -Mdir obj_dir \
    && ./obj_dir/Vtb_fpga_core | tee /dev/stderr | grep -q "ALL CHECKS PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

exit 0
